/* sources.f */
+incdir+verilog
verilog/awg_pkg.sv
verilog/awg_cfg_if.sv
verilog/awg_stream_if.sv
verilog/awg_wb_regs.sv
verilog/awg_channel.sv
verilog/awg_output_stage.sv
verilog/awg_top.sv
tb/awg_tb.sv

/* tb/awg_tb.sv */
// testbench of the awg waveform generator with a Wishbone host, reference model and port assertions
`include "awg_consts.svh"

module awg_tb import awg_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD = 10;
  localparam int ADR_W      = `AWG_WB_ADR_W;
  localparam int DAT_W      = `AWG_WB_DAT_W;
  localparam int CHAN_W     = $clog2(`AWG_CHANNELS);
  localparam int WORD_W     = $clog2(`AWG_DEPTH);
  // six bursts of at most three full frames, plus the whole buffer load several times over
  localparam int BURST_CYCLES = 6 * (`AWG_DEPTH * 3 + 16);
  localparam int BUS_CYCLES   = 4 * (`AWG_CHANNELS * `AWG_DEPTH + 64);
  localparam int TIMEOUT_NS   = (BURST_CYCLES + BUS_CYCLES + 200) * CLK_PERIOD;

  logic                             dac_clk;
  logic                             dac_reset;
  logic                             wb_cyc;
  logic                             wb_stb;
  logic                             wb_we;
  logic [ADR_W-1:0]                 wb_adr;
  logic [DAT_W-1:0]                 wb_dat_w;
  logic [DAT_W-1:0]                 wb_dat_r;
  logic                             wb_ack;
  sample_word_t [`AWG_CHANNELS-1:0] dac_data;
  logic                             dac_valid;
  logic [`AWG_CHANNELS-1:0]         dac_trigger;

  //////////////////////////////
  // reference model state
  //////////////////////////////

  sample_word_t wave [`AWG_CHANNELS][`AWG_DEPTH];
  // words per frame, frames per burst and trigger mode of each channel
  int           frame_words [`AWG_CHANNELS] = '{5, 12, 9, 20};
  int           frames [`AWG_CHANNELS]      = '{3, 1, 2, 2};
  trig_mode_t   modes [`AWG_CHANNELS]       = '{trig_frame, trig_off, trig_burst, trig_frame};

  int error_count;
  int tests_run;
  int tests_failed;
  int test_start_errors;

  awg_top awg_top_inst (
    .dac_clk     (dac_clk),
    .dac_reset   (dac_reset),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_w    (wb_dat_w),
    .wb_dat_r    (wb_dat_r),
    .wb_ack      (wb_ack),
    .dac_data    (dac_data),
    .dac_valid   (dac_valid),
    .dac_trigger (dac_trigger)
  );

  always #(CLK_PERIOD / 2) dac_clk = ~dac_clk;

  task automatic flag_error(input string msg);
    $display("ERROR %0t: %s", $time, msg);
    error_count++;
  endtask

  //////////////////////////////
  // port assertions
  //////////////////////////////

  // outside a burst the DAC side is silent
  a_quiet: assert property (@(posedge dac_clk) disable iff (dac_reset)
    !dac_valid |-> (dac_data == '0 && dac_trigger == '0))
    else flag_error("data or trigger active while dac_valid is low");

  // a pending request is acked on the next edge
  a_ack_next: assert property (@(posedge dac_clk) disable iff (dac_reset)
    (wb_cyc && wb_stb && !wb_ack) |=> wb_ack)
    else flag_error("request not acked one cycle later");

  // every ack answers a request pending in the cycle before
  a_ack_req: assert property (@(posedge dac_clk) disable iff (dac_reset)
    wb_ack |-> $past(wb_cyc && wb_stb && !wb_ack))
    else flag_error("ack without a pending request");

  // ack lasts exactly one cycle
  a_ack_once: assert property (@(posedge dac_clk) disable iff (dac_reset)
    wb_ack |=> !wb_ack)
    else flag_error("ack held for more than one cycle");

  //////////////////////////////
  // Wishbone master
  //////////////////////////////

  task automatic bus_write(input logic [ADR_W-1:0] adr, input logic [DAT_W-1:0] data);
    @(posedge dac_clk);
    #1;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_dat_w = data;
    // returns 1 ns after the ack edge
    do begin
      @(posedge dac_clk);
      #1;
    end while (!wb_ack);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic bus_read(input logic [ADR_W-1:0] adr, output logic [DAT_W-1:0] data);
    @(posedge dac_clk);
    #1;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    do begin
      @(posedge dac_clk);
      #1;
    end while (!wb_ack);
    data   = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  task automatic read_expect(input logic [ADR_W-1:0] adr, input logic [DAT_W-1:0] exp,
                             input string what);
    logic [DAT_W-1:0] got;
    bus_read(adr, got);
    assert (got == exp)
      else flag_error($sformatf("%s read 0x%0h, expected 0x%0h", what, got, exp));
  endtask

  // bit 11 selects memory, then channel, then word
  function automatic logic [ADR_W-1:0] mem_addr(input int c, input int i);
    logic [ADR_W-1:0] a;
    a = '0;
    a[`AWG_MEM_SEL_BIT] = 1'b1;
    a[WORD_W +: CHAN_W] = CHAN_W'(c);
    a[WORD_W-1:0] = WORD_W'(i);
    return a;
  endfunction

  //////////////////////////////
  // reference model
  //////////////////////////////

  // word k of the burst with frames back to back and silence after
  function automatic sample_word_t expected_word(input int c, input int k);
    if (k >= frame_words[c] * frames[c]) begin
      return '0;
    end
    return wave[c][k % frame_words[c]];
  endfunction

  function automatic logic expected_trigger(input int c, input int k);
    if (k >= frame_words[c] * frames[c] || (k % frame_words[c]) != 0) begin
      return 1'b0;
    end
    return (modes[c] == trig_frame) || (modes[c] == trig_burst && k == 0);
  endfunction

  // called right after the start ack and compares every port cycle until well past the end
  task automatic check_burst(input bit check_data, input bit check_trig);
    int max_words;
    max_words = 0;
    for (int c = 0; c < `AWG_CHANNELS; c++) begin
      if (frame_words[c] * frames[c] > max_words) begin
        max_words = frame_words[c] * frames[c];
      end
    end
    repeat (`AWG_OUT_LATENCY) @(posedge dac_clk);
    for (int k = 0; k < max_words + 4; k++) begin
      @(negedge dac_clk);
      assert (dac_valid == (k < max_words))
        else flag_error($sformatf("dac_valid %0b at word %0d", dac_valid, k));
      for (int c = 0; c < `AWG_CHANNELS; c++) begin
        if (check_data) begin
          assert (dac_data[c] == expected_word(c, k))
            else flag_error($sformatf("ch%0d word %0d is 0x%0h, expected 0x%0h",
                                      c, k, dac_data[c], expected_word(c, k)));
        end
        if (check_trig) begin
          assert (dac_trigger[c] == expected_trigger(c, k))
            else flag_error($sformatf("ch%0d trigger %0b at word %0d",
                                      c, dac_trigger[c], k));
        end
      end
    end
  endtask

  task automatic check_silent(input int cycles);
    for (int k = 0; k < cycles; k++) begin
      @(negedge dac_clk);
      assert (!dac_valid && dac_trigger == '0 && dac_data == '0)
        else flag_error("DAC ports not silent");
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (error_count == test_start_errors) begin
      $display("test %0d %s: pass", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: fail, %0d errors", tests_run, name,
               error_count - test_start_errors);
    end
    test_start_errors = error_count;
  endtask

  //////////////////////////////
  // watchdog
  //////////////////////////////

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the run did not complete within %0d ns", TIMEOUT_NS);
    $display("Result: FAILED");
    $finish;
  end

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin
    dac_clk   = 1'b0;
    dac_reset = 1'b1;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_dat_w  = '0;
    error_count       = 0;
    tests_run         = 0;
    tests_failed      = 0;
    test_start_errors = 0;
    void'($urandom(32'hffc4));
    repeat (3) @(posedge dac_clk);
    #1;
    dac_reset = 1'b0;

    // test 1 checks the silent ports after reset
    check_silent(10);
    finish_test("idle after reset");

    // test 2 loads waveforms and config and reads them back
    for (int c = 0; c < `AWG_CHANNELS; c++) begin
      for (int i = 0; i < `AWG_DEPTH; i++) begin
        wave[c][i] = $urandom;
        bus_write(mem_addr(c, i), wave[c][i]);
      end
      bus_write(ADR_W'(`AWG_REG_DEPTH_BASE + c), frame_words[c] - 1);
      bus_write(ADR_W'(`AWG_REG_TRIG_BASE + c), DAT_W'(modes[c]));
      bus_write(ADR_W'(`AWG_REG_BURST_BASE + c), frames[c]);
    end
    for (int c = 0; c < `AWG_CHANNELS; c++) begin
      read_expect(ADR_W'(`AWG_REG_DEPTH_BASE + c), frame_words[c] - 1, "depth");
      read_expect(ADR_W'(`AWG_REG_TRIG_BASE + c), DAT_W'(modes[c]), "trigger mode");
      // stored as count minus one
      read_expect(ADR_W'(`AWG_REG_BURST_BASE + c), frames[c] - 1, "burst length");
    end
    read_expect(mem_addr(2, 3), '0, "buffer memory");
    read_expect(`AWG_REG_STATUS, '0, "status while idle");
    check_silent(4);
    finish_test("register read back");

    // test 3 compares the sample stream with the model
    bus_write(`AWG_REG_CTRL, 32'h1);
    check_burst(1'b1, 1'b0);
    finish_test("burst playback");

    // test 4 checks the trigger modes
    bus_write(`AWG_REG_CTRL, 32'h1);
    check_burst(1'b0, 1'b1);
    finish_test("trigger modes");

    // test 5 stops mid-burst and replays from the start
    bus_write(`AWG_REG_CTRL, 32'h1);
    read_expect(`AWG_REG_STATUS, 32'h1, "status during burst");
    repeat (8) @(posedge dac_clk);
    bus_write(`AWG_REG_CTRL, 32'h2);
    repeat (3) @(posedge dac_clk);
    check_silent(8);
    read_expect(`AWG_REG_STATUS, '0, "status after stop");
    bus_write(`AWG_REG_CTRL, 32'h1);
    check_burst(1'b1, 1'b1);
    finish_test("stop and restart");

    // test 6 writes while active and expects the model to stay unchanged
    bus_write(`AWG_REG_CTRL, 32'h1);
    fork
      check_burst(1'b1, 1'b1);
      begin
        bus_write(mem_addr(0, 0), ~wave[0][0]);
        bus_write(mem_addr(3, 1), ~wave[3][1]);
        bus_write(ADR_W'(`AWG_REG_DEPTH_BASE + 1), 32'd3);
        bus_write(ADR_W'(`AWG_REG_BURST_BASE + 2), 32'd5);
        bus_write(ADR_W'(`AWG_REG_TRIG_BASE + 1), DAT_W'(trig_frame));
        // a second start has no effect either
        bus_write(`AWG_REG_CTRL, 32'h1);
      end
    join
    read_expect(`AWG_REG_STATUS, '0, "status after burst end");
    read_expect(ADR_W'(`AWG_REG_DEPTH_BASE + 1), frame_words[1] - 1, "locked depth");
    read_expect(ADR_W'(`AWG_REG_BURST_BASE + 2), frames[2] - 1, "locked burst length");
    bus_write(`AWG_REG_CTRL, 32'h1);
    check_burst(1'b1, 1'b1);
    finish_test("write lock during burst");

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
    if (error_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* verilog/awg_cfg_if.sv */
// awg config interface: buffer writes, per-channel settings and run state to the channels
`include "awg_consts.svh"

interface awg_cfg_if import awg_pkg::*; ();

  // buffer write port, at most one word per cycle across all channels
  logic         wr_en;
  chan_idx_t    wr_chan;
  frame_addr_t  wr_addr;
  sample_word_t wr_data;

  // per-channel settings, only changed while idle
  // last buffer address of a frame
  frame_addr_t address_max [`AWG_CHANNELS];
  // frames per burst minus one
  burst_len_t  burst_length [`AWG_CHANNELS];
  trig_mode_t  trig_mode [`AWG_CHANNELS];

  // high for the whole burst, low also clears channel sequencers
  logic active;

  // register block side
  modport regs (
    output wr_en, wr_chan, wr_addr, wr_data,
    output address_max, burst_length, trig_mode,
    output active
  );

  // each channel picks its own array entry
  modport channel (
    input wr_en, wr_chan, wr_addr, wr_data,
    input address_max, burst_length, trig_mode,
    input active
  );

endinterface

/* verilog/awg_channel.sv */
// awg channel: waveform buffer, frame and burst sequencer, trigger and output pipeline
`include "awg_consts.svh"

module awg_channel import awg_pkg::*; #(
  parameter chan_idx_t CHANNEL_ID = '0
) (
  input  logic          dac_clk,
  input  logic          dac_reset,
  awg_cfg_if.channel    cfg,
  awg_stream_if.source  stream
);

  sample_word_t mem [`AWG_DEPTH];

  frame_addr_t  last_addr;
  burst_len_t   last_frame;
  trig_mode_t   mode;

  frame_addr_t  rd_addr;
  burst_len_t   frame_cnt;
  logic         done_flag;
  logic         at_last;
  logic         final_frame;
  logic         issuing;
  logic         trig_hit;

  // first pipeline stage
  sample_word_t rd_data;
  logic         play_s1;
  logic         trig_s1;
  logic         done_s1;

  // own entries of the shared config
  assign last_addr  = cfg.address_max[CHANNEL_ID];
  assign last_frame = cfg.burst_length[CHANNEL_ID];
  assign mode       = cfg.trig_mode[CHANNEL_ID];

  //////////////////////////////
  // waveform buffer
  //////////////////////////////

  // write from the bus while idle, read every cycle into the first stage
  always_ff @(posedge dac_clk) begin
    if (cfg.wr_en && (cfg.wr_chan == CHANNEL_ID)) begin
      mem[cfg.wr_addr] <= cfg.wr_data;
    end
    rd_data <= mem[rd_addr];
  end

  //////////////////////////////
  // read sequencer
  //////////////////////////////

  assign at_last     = (rd_addr == last_addr);
  assign final_frame = (frame_cnt == last_frame);
  // current address is a real burst word
  assign issuing     = cfg.active & ~done_flag;

  // trigger at the start of a frame, burst mode only on frame 0
  assign trig_hit = issuing & (rd_addr == '0) &
                    ((mode == trig_frame) | ((mode == trig_burst) & (frame_cnt == '0)));

  // address 0 is presented as soon as active rises
  always_ff @(posedge dac_clk) begin
    if (dac_reset) begin
      rd_addr   <= '0;
      frame_cnt <= '0;
      done_flag <= 1'b0;
    end else if (!cfg.active) begin
      // idle or stopped, rewind for the next start
      rd_addr   <= '0;
      frame_cnt <= '0;
      done_flag <= 1'b0;
    end else if (!done_flag) begin
      if (at_last) begin
        rd_addr <= '0;
        // last word of the last frame goes out now
        if (final_frame) begin
          done_flag <= 1'b1;
        end else begin
          frame_cnt <= frame_cnt + 1'b1;
        end
      end else begin
        rd_addr <= rd_addr + 1'b1;
      end
    end
  end

  //////////////////////////////
  // output pipeline
  //////////////////////////////

  // status bits follow the word through both stages
  always_ff @(posedge dac_clk) begin
    if (dac_reset) begin
      play_s1        <= 1'b0;
      trig_s1        <= 1'b0;
      done_s1        <= 1'b0;
      stream.sample  <= '0;
      stream.playing <= 1'b0;
      stream.trigger <= 1'b0;
      stream.done    <= 1'b0;
    end else begin
      play_s1 <= issuing;
      trig_s1 <= trig_hit;
      done_s1 <= done_flag;
      // zero select, finished or idle channels drive silence
      stream.sample  <= play_s1 ? rd_data : '0;
      stream.playing <= play_s1;
      stream.trigger <= trig_s1;
      stream.done    <= done_s1;
    end
  end

endmodule

/* verilog/awg_consts.svh */
// awg constants: sizes, Wishbone register map and output latency of the waveform generator
`ifndef AWG_CONSTS_SVH
`define AWG_CONSTS_SVH

//////////////////////////////
// sizes
//////////////////////////////

// number of independent output channels
`define AWG_CHANNELS 4
// buffer words per channel, one word per dac_clk cycle on readout
`define AWG_DEPTH 64
`define AWG_SAMPLE_WIDTH 16
`define AWG_PARALLEL_SAMPLES 2

//////////////////////////////
// wishbone register map
//////////////////////////////

`define AWG_WB_ADR_W 12
`define AWG_WB_DAT_W 32
// per-channel registers sit at base + channel number
`define AWG_REG_DEPTH_BASE 12'h000
`define AWG_REG_TRIG_BASE 12'h010
`define AWG_REG_BURST_BASE 12'h020
// bit 0 start, bit 1 stop
`define AWG_REG_CTRL 12'h030
// bit 0 active
`define AWG_REG_STATUS 12'h031
// set selects buffer memory, bits 7:6 channel, bits 5:0 word
`define AWG_MEM_SEL_BIT 11

// edges from start ack to first word on the dac ports
`define AWG_OUT_LATENCY 3

`endif

/* verilog/awg_output_stage.sv */
// awg output stage: registers all channels onto the DAC ports and flags the burst end
`include "awg_consts.svh"

module awg_output_stage import awg_pkg::*; (
  input  logic                              dac_clk,
  input  logic                              dac_reset,
  awg_stream_if.sink                        streams [`AWG_CHANNELS],
  output sample_word_t [`AWG_CHANNELS-1:0]  dac_data,
  output logic                              dac_valid,
  output logic [`AWG_CHANNELS-1:0]          dac_trigger,
  output logic                              burst_done
);

  sample_word_t [`AWG_CHANNELS-1:0] sample_in;
  logic [`AWG_CHANNELS-1:0]         trigger_in;
  logic [`AWG_CHANNELS-1:0]         playing_in;
  logic [`AWG_CHANNELS-1:0]         done_in;
  // all channels done, one cycle back
  logic                             all_done_q;

  // interface array needs constant indices
  for (genvar c = 0; c < `AWG_CHANNELS; c++) begin : g_gather
    assign sample_in[c]  = streams[c].sample;
    assign trigger_in[c] = streams[c].trigger;
    assign playing_in[c] = streams[c].playing;
    assign done_in[c]    = streams[c].done;
  end

  always_ff @(posedge dac_clk) begin
    if (dac_reset) begin
      dac_data    <= '0;
      dac_trigger <= '0;
      dac_valid   <= 1'b0;
      all_done_q  <= 1'b0;
      burst_done  <= 1'b0;
    end else begin
      dac_data    <= sample_in;
      dac_trigger <= trigger_in;
      // valid while the longest channel still plays
      dac_valid   <= |playing_in;
      all_done_q  <= &done_in;
      // single pulse on the rise, done flags linger until the channels rewind
      burst_done  <= (&done_in) & ~all_done_q;
    end
  end

endmodule

/* verilog/awg_pkg.sv */
// awg package: shared data types of the waveform generator datapath and control
`include "awg_consts.svh"

package awg_pkg;

  //////////////////////////////
  // datapath types
  //////////////////////////////

  // one dac word, parallel samples packed lowest sample first
  typedef logic [`AWG_PARALLEL_SAMPLES*`AWG_SAMPLE_WIDTH-1:0] sample_word_t;

  // buffer address, also used for the stored last address of a frame
  typedef logic [$clog2(`AWG_DEPTH)-1:0] frame_addr_t;

  // frame counter and stored burst length minus one
  typedef logic [15:0] burst_len_t;

  // channel select on the write path
  typedef logic [$clog2(`AWG_CHANNELS)-1:0] chan_idx_t;

  //////////////////////////////
  // control types
  //////////////////////////////

  // trigger output behaviour per channel
  typedef enum logic [1:0] {
    // no pulse at all
    trig_off   = 2'd0,
    // pulse with the first word of the burst
    trig_burst = 2'd1,
    // pulse with the first word of each frame
    trig_frame = 2'd2
  } trig_mode_t;

  // run state owned by the register block
  typedef enum logic {
    run_idle   = 1'b0,
    run_active = 1'b1
  } run_state_t;

endpackage

/* verilog/awg_stream_if.sv */
// awg stream interface: one channel's sample, trigger and status into the output stage
`include "awg_consts.svh"

interface awg_stream_if import awg_pkg::*; ();

  // all four signals refer to the same cycle

  // sample word, zero whenever the channel is not playing
  sample_word_t sample;
  // marks the sample as the start of a burst or frame
  logic trigger;
  // sample belongs to the burst
  logic playing;
  // channel has issued its final word
  logic done;

  // channel side
  modport source (
    output sample, trigger, playing, done
  );

  // output stage side
  modport sink (
    input sample, trigger, playing, done
  );

endinterface

/* verilog/awg_top.sv */
// awg top: multi-channel arbitrary waveform generator with a Wishbone host port
`include "awg_consts.svh"

module awg_top import awg_pkg::*; (
  input  logic                              dac_clk,
  input  logic                              dac_reset,
  // wishbone classic slave
  input  logic                              wb_cyc,
  input  logic                              wb_stb,
  input  logic                              wb_we,
  input  logic [`AWG_WB_ADR_W-1:0]          wb_adr,
  input  logic [`AWG_WB_DAT_W-1:0]          wb_dat_w,
  output logic [`AWG_WB_DAT_W-1:0]          wb_dat_r,
  output logic                              wb_ack,
  // dac side, real time, no back-pressure
  output sample_word_t [`AWG_CHANNELS-1:0]  dac_data,
  output logic                              dac_valid,
  output logic [`AWG_CHANNELS-1:0]          dac_trigger
);

  // end of burst, back into the run FSM
  logic burst_done;

  awg_cfg_if    cfg_if ();
  awg_stream_if stream_if [`AWG_CHANNELS] ();

  //////////////////////////////
  // register block
  //////////////////////////////

  awg_wb_regs regs_inst (
    .dac_clk    (dac_clk),
    .dac_reset  (dac_reset),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .burst_done (burst_done),
    .cfg        (cfg_if)
  );

  //////////////////////////////
  // channels and output
  //////////////////////////////

  // all channels read out in lockstep from the shared active flag
  for (genvar c = 0; c < `AWG_CHANNELS; c++) begin : g_chan
    awg_channel #(
      .CHANNEL_ID (chan_idx_t'(c))
    ) chan_inst (
      .dac_clk   (dac_clk),
      .dac_reset (dac_reset),
      .cfg       (cfg_if),
      .stream    (stream_if[c])
    );
  end

  awg_output_stage out_inst (
    .dac_clk     (dac_clk),
    .dac_reset   (dac_reset),
    .streams     (stream_if),
    .dac_data    (dac_data),
    .dac_valid   (dac_valid),
    .dac_trigger (dac_trigger),
    .burst_done  (burst_done)
  );

endmodule

/* verilog/awg_wb_regs.sv */
// awg register block: Wishbone classic slave, channel config registers and run FSM
`include "awg_consts.svh"

module awg_wb_regs import awg_pkg::*; (
  input  logic                     dac_clk,
  input  logic                     dac_reset,
  input  logic                     wb_cyc,
  input  logic                     wb_stb,
  input  logic                     wb_we,
  input  logic [`AWG_WB_ADR_W-1:0] wb_adr,
  input  logic [`AWG_WB_DAT_W-1:0] wb_dat_w,
  output logic [`AWG_WB_DAT_W-1:0] wb_dat_r,
  output logic                     wb_ack,
  input  logic                     burst_done,
  awg_cfg_if.regs                  cfg
);

  localparam int CHAN_W  = $bits(chan_idx_t);
  localparam int ADDR_W  = $bits(frame_addr_t);
  localparam int BURST_W = $bits(burst_len_t);

  logic                     req;
  logic                     wr_req;
  logic                     mem_sel;
  logic [`AWG_WB_ADR_W-1:0] reg_base;
  chan_idx_t                reg_chan;
  logic                     depth_sel;
  logic                     trig_sel;
  logic                     burst_sel;
  logic                     ctrl_sel;
  logic                     status_sel;
  logic                     cfg_open;
  logic                     start_cmd;
  logic                     stop_cmd;
  logic [`AWG_WB_DAT_W-1:0] rd_mux;
  run_state_t               state;

  //////////////////////////////
  // address decode
  //////////////////////////////

  // new request only while ack is low, so each request is answered once
  assign req    = wb_cyc & wb_stb & ~wb_ack;
  assign wr_req = req & wb_we;

  assign mem_sel  = wb_adr[`AWG_MEM_SEL_BIT];
  // low bits pick the channel, the rest picks the register group
  assign reg_base = {wb_adr[`AWG_WB_ADR_W-1:CHAN_W], {CHAN_W{1'b0}}};
  assign reg_chan = wb_adr[CHAN_W-1:0];

  assign depth_sel  = ~mem_sel & (reg_base == `AWG_REG_DEPTH_BASE);
  assign trig_sel   = ~mem_sel & (reg_base == `AWG_REG_TRIG_BASE);
  assign burst_sel  = ~mem_sel & (reg_base == `AWG_REG_BURST_BASE);
  assign ctrl_sel   = (wb_adr == `AWG_REG_CTRL);
  assign status_sel = (wb_adr == `AWG_REG_STATUS);

  // config and buffer writes only land while idle, otherwise acked and dropped
  assign cfg_open = (state == run_idle);

  assign start_cmd = wr_req & ctrl_sel & wb_dat_w[0];
  assign stop_cmd  = wr_req & ctrl_sel & wb_dat_w[1];

  //////////////////////////////
  // buffer write path
  //////////////////////////////

  // combinational so the word lands in the buffer on the ack edge
  assign cfg.wr_en   = wr_req & mem_sel & cfg_open;
  // bits 7:6 channel, bits 5:0 word index
  assign cfg.wr_chan = wb_adr[ADDR_W +: CHAN_W];
  assign cfg.wr_addr = wb_adr[ADDR_W-1:0];
  assign cfg.wr_data = wb_dat_w;

  // config registers
  always_ff @(posedge dac_clk) begin
    if (dac_reset) begin
      for (int c = 0; c < `AWG_CHANNELS; c++) begin
        cfg.address_max[c]  <= '0;
        cfg.burst_length[c] <= '0;
        cfg.trig_mode[c]    <= trig_off;
      end
    end else if (wr_req && cfg_open) begin
      if (depth_sel) begin
        cfg.address_max[reg_chan] <= wb_dat_w[ADDR_W-1:0];
      end
      if (trig_sel) begin
        cfg.trig_mode[reg_chan] <= trig_mode_t'(wb_dat_w[1:0]);
      end
      // host writes a frame count, the sequencer compares against count - 1
      if (burst_sel) begin
        cfg.burst_length[reg_chan] <= wb_dat_w[BURST_W-1:0] - 1'b1;
      end
    end
  end

  //////////////////////////////
  // run FSM
  //////////////////////////////

  // start while active and stop while idle fall through unchanged
  always_ff @(posedge dac_clk) begin
    if (dac_reset) begin
      state <= run_idle;
    end else begin
      case (state)
        run_idle: begin
          if (start_cmd) begin
            state <= run_active;
          end
        end
        run_active: begin
          if (stop_cmd || burst_done) begin
            state <= run_idle;
          end
        end
        default: state <= run_idle;
      endcase
    end
  end

  assign cfg.active = (state == run_active);

  //////////////////////////////
  // read back and ack
  //////////////////////////////

  // buffer memory and unmapped addresses read as zero
  always_comb begin
    rd_mux = '0;
    if (depth_sel) begin
      rd_mux[ADDR_W-1:0] = cfg.address_max[reg_chan];
    end
    if (trig_sel) begin
      rd_mux[1:0] = cfg.trig_mode[reg_chan];
    end
    if (burst_sel) begin
      rd_mux[BURST_W-1:0] = cfg.burst_length[reg_chan];
    end
    if (status_sel) begin
      rd_mux[0] = cfg.active;
    end
  end

  // single-cycle slave, ack one edge after the request
  always_ff @(posedge dac_clk) begin
    if (dac_reset) begin
      wb_ack   <= 1'b0;
      wb_dat_r <= '0;
    end else begin
      wb_ack <= req;
      if (req && !wb_we) begin
        wb_dat_r <= rd_mux;
      end
    end
  end

endmodule
